// ==== logic/fifo_cfg_pkg.sv ====
//**************************************************
// Sizing constants for the single-clock FIFO
// Import into a module body to pick up the RAM
// geometry and the full threshold
//**************************************************

package fifo_cfg_pkg;

	// RAM geometry
	localparam int ADR_WIDTH = 4;		// Address and pointer bits
	localparam int DAT_WIDTH = 16;		// Bits per stored word

	// Number of RAM words
	localparam int DEPTH = 2 ** ADR_WIDTH;

	// Full threshold
	// Equal pointers mean empty, so one word always stays unused
	localparam int FULL_LEVEL = DEPTH - 1;

endpackage

// ==== logic/fifo_types_pkg.sv ====
//**************************************************
// Vector types and packed port structs of the FIFO
// Used in port lists by scoped name and in module
// bodies through a wildcard import
//**************************************************

package fifo_types_pkg;

	import fifo_cfg_pkg::*;

	// Widths with a meaning
	typedef logic [ADR_WIDTH-1:0] adr_t;	// RAM address, pointers
	typedef logic [DAT_WIDTH-1:0] dat_t;	// One data word
	typedef logic [ADR_WIDTH:0] wrds_t;	// Used words, one extra bit

	// Write side, strobe and data
	typedef struct packed
	{
		logic wr;			// Write strobe
		dat_t dat;			// Write data
	} wr_port_t;

	// Read side output
	typedef struct packed
	{
		logic de;			// Data enable
		dat_t dat;			// Read data
	} rd_data_t;

	// Status bundle
	typedef struct packed
	{
		wrds_t wrds;		// Registered used-word count
		logic empty;		// Combinational from the pointers
		logic full;			// From the word count
	} fifo_status_t;

endpackage

// ==== logic/fifo_ptr_ctrl.sv ====
//**************************************************
// Write and read pointers of the FIFO
// Also gives the empty flag and the read acceptance
// that drives the RAM data enable
//**************************************************

`timescale 1ns/1ps

module fifo_ptr_ctrl
(
	input logic RST_IN,							// Clock
	input logic CLK_IN,							// Reset
	input logic clr,
	input logic wr,
	input logic rd_en,
	input logic rd,
	output fifo_types_pkg::adr_t wr_adr,
	output fifo_types_pkg::adr_t rd_adr,
	output logic rd_accept,
	output logic empty
);

	import fifo_cfg_pkg::*;
	import fifo_types_pkg::*;

	localparam adr_t LAST_ADR = adr_t'(DEPTH - 1);

	logic wr_take;			// Write taken this edge

	// Clear wins over a write
	assign wr_take = wr && !clr;

	// Read needs the enable level, a request and data
	assign rd_accept = rd_en && rd && !empty && !clr;

	// Equal pointers mean nothing stored
	assign empty = (wr_adr == rd_adr);

	// Write pointer
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			wr_adr <= '0;
		else if (clr)
			wr_adr <= '0;
		else if (wr_take)
		begin
			if (wr_adr == LAST_ADR)
				wr_adr <= '0;			// Wrap
			else
				wr_adr <= wr_adr + 1'b1;
		end
	end

	// Read pointer
	// Holds while rd_en is low
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			rd_adr <= '0;
		else if (clr)
			rd_adr <= '0;
		else if (rd_accept)
		begin
			if (rd_adr == LAST_ADR)
				rd_adr <= '0;			// Wrap
			else
				rd_adr <= rd_adr + 1'b1;
		end
	end

	// A write with no read in the same cycle must not catch up with the
	// read pointer, otherwise the FIFO would look empty after overflowing
	a_no_overflow : assert property
	(
		@(posedge RST_IN) disable iff (CLK_IN)
		(wr_take && !rd_accept) |=> (wr_adr != rd_adr)
	)
	else
		$error("FIFO overflow, write pointer reached read pointer");

endmodule

// ==== logic/fifo_sdp_ram.sv ====
//**************************************************
// Simple dual-port RAM, one clock, read first
// Read port registered under rd_en with one cycle
// latency, data enable registered alongside
//**************************************************

`timescale 1ns/1ps

module fifo_sdp_ram
(
	input logic RST_IN,							// Clock
	input logic CLK_IN,							// Reset
	input fifo_types_pkg::wr_port_t wr_port,
	input fifo_types_pkg::adr_t wr_adr,
	input fifo_types_pkg::adr_t rd_adr,
	input logic rd_en,
	input logic rd_accept,
	output fifo_types_pkg::rd_data_t rd_data
);

	import fifo_cfg_pkg::*;
	import fifo_types_pkg::*;

	dat_t mem [DEPTH];		// Storage array
	dat_t rd_dat;			// Output data register
	logic de;				// Data enable register

	// Write port
	always_ff @(posedge RST_IN)
	begin
		if (wr_port.wr)
			mem[wr_adr] <= wr_port.dat;
	end

	// Read port
	// Old contents win on an address collision
	always_ff @(posedge RST_IN)
	begin
		if (rd_en)
			rd_dat <= mem[rd_adr];
	end

	// Data enable, one cycle behind the accepted read
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			de <= 1'b0;
		else if (rd_en)
			de <= rd_accept;
	end

	assign rd_data = '{de: de, dat: rd_dat};

	// A fresh data enable pairs with one step of the read pointer
	// Only checked where the register was enabled at the last edge
	a_de_follows_read : assert property
	(
		@(posedge RST_IN) disable iff (CLK_IN)
		($past(rd_en) && de) |-> (rd_adr == adr_t'($past(rd_adr) + 1'b1))
	)
	else
		$error("Data enable without an accepted read");

endmodule

// ==== logic/fifo_status.sv ====
//**************************************************
// Used-word count and full flag of the FIFO
// Count registered from the pointer difference
// and full decoded from the count
//**************************************************

`timescale 1ns/1ps

module fifo_status
(
	input logic RST_IN,							// Clock
	input logic CLK_IN,							// Reset
	input fifo_types_pkg::adr_t wr_adr,
	input fifo_types_pkg::adr_t rd_adr,
	output fifo_types_pkg::wrds_t wrds,
	output logic full
);

	import fifo_cfg_pkg::*;
	import fifo_types_pkg::*;

	localparam wrds_t FULL_WRDS = wrds_t'(FULL_LEVEL);

	adr_t diff;			// Pointer distance

	// Address width arithmetic wraps modulo DEPTH
	assign diff = wr_adr - rd_adr;

	// One cycle behind the pointers
	always_ff @(posedge RST_IN or posedge CLK_IN)
	begin
		if (CLK_IN)
			wrds <= '0;
		else
			wrds <= {1'b0, diff};
	end

	assign full = (wrds == FULL_WRDS);		// From the count

	// The count steps by one word at most unless a clear drops it to zero
	a_wrds_step : assert property
	(
		@(posedge RST_IN) disable iff (CLK_IN)
		(wrds == '0) || (wrds == $past(wrds))
			|| (wrds == wrds_t'($past(wrds) + 1'b1))
			|| (wrds == wrds_t'($past(wrds) - 1'b1))
	)
	else
		$error("Word count changed by more than one word");

endmodule

// ==== logic/fifo_top.sv ====
//**************************************************
// Single-clock FIFO, 16 words of 16 bits, burst mode
// Write any cycle, read under rd_en, data enable
// follows each accepted read by one cycle
//**************************************************

`timescale 1ns/1ps

module fifo_top
(
	input logic RST_IN,							// Clock
	input logic CLK_IN,							// Reset, async, active high
	input logic clr,							// Synchronous clear
	input fifo_types_pkg::wr_port_t wr_port,
	input logic rd_en,							// Read enable level
	input logic rd,
	output fifo_types_pkg::rd_data_t rd_data,
	output fifo_types_pkg::fifo_status_t status
);

	import fifo_types_pkg::*;

	adr_t wr_adr;
	adr_t rd_adr;
	logic rd_accept;
	logic empty;
	wrds_t wrds;
	logic full;

	// Pointers, read acceptance and empty
	fifo_ptr_ctrl u_ptr_ctrl
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(clr),
		.wr			(wr_port.wr),
		.rd_en		(rd_en),
		.rd			(rd),
		.wr_adr		(wr_adr),
		.rd_adr		(rd_adr),
		.rd_accept	(rd_accept),
		.empty		(empty)
	);

	// Storage with registered read port
	fifo_sdp_ram u_sdp_ram
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.wr_port	(wr_port),
		.wr_adr		(wr_adr),
		.rd_adr		(rd_adr),
		.rd_en		(rd_en),
		.rd_accept	(rd_accept),
		.rd_data	(rd_data)
	);

	// Used words and full
	fifo_status u_status
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.wr_adr		(wr_adr),
		.rd_adr		(rd_adr),
		.wrds		(wrds),
		.full		(full)
	);

	assign status = '{wrds: wrds, empty: empty, full: full};

endmodule

// ==== verification/fifo_tb.sv ====
//**************************************************
// Testbench for the single-clock FIFO
// Reads its tests from verification/fifo_cases.txt,
// mirrors the FIFO in a queue and checks read data
// and status
// Run through run_sim.sh
//**************************************************

`timescale 1ns/1ps

module fifo_tb;

	import fifo_cfg_pkg::*;
	import fifo_types_pkg::*;

	logic RST_IN;			// Clock
	logic CLK_IN;			// Reset, active high
	logic clr;
	wr_port_t wr_port;
	logic rd_en;
	logic rd;
	rd_data_t rd_data;
	fifo_status_t status;

	// Test table
	string case_name [$];
	int case_wr [$];
	int case_rd [$];
	int case_gap [$];
	int case_clr [$];
	int case_rde [$];

	dat_t ref_q [$];		// Written but not yet read
	logic [31:0] lfsr;

	// Output register model
	logic pend_en;			// rd_en seen at the coming edge
	logic pend_acc;
	dat_t pend_dat;
	logic cur_de;			// Expected after the last edge
	logic cur_new;			// Register was enabled at the last edge
	dat_t cur_dat;

	string cur_name;
	logic checking;
	event outputs_checked;	// Read side compared at this falling edge
	int err_cnt;
	int check_cnt;
	int words_out;
	int cycle_cnt;
	int cycle_limit;

	fifo_top u_fifo_top
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(clr),
		.wr_port	(wr_port),
		.rd_en		(rd_en),
		.rd			(rd),
		.rd_data	(rd_data),
		.status		(status)
	);

	// 4 ns clock
	initial
	begin
		RST_IN = 1'b0;
		forever
			#2 RST_IN = ~RST_IN;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per data bit
	function automatic dat_t random_word();
		dat_t w;
		int i;
		for (i = 0; i < DAT_WIDTH; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w[i] = lfsr[0];
		end
		return w;
	endfunction

	task automatic report_mismatch(input string what, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		err_cnt++;
		$display("[FAIL] %s %s: expected %h, actual %h", cur_name, what, exp_val, act_val);
	endtask

	// One clock of stimulus with the model stepped on the same edge
	task automatic drive_cycle(input logic wr, input logic rd_req, input logic en,
		input logic clr_req, output logic accepted);
		dat_t d;
		d = '0;
		@(posedge RST_IN);
		cur_new = pend_en;				// Last choices sampled now
		if (pend_en)
		begin
			cur_de = pend_acc;
			cur_dat = pend_dat;
		end
		accepted = rd_req && en && !clr_req && (ref_q.size() != 0);
		if (wr)
			d = random_word();
		wr_port <= '{wr: wr, dat: d};
		rd <= rd_req;
		rd_en <= en;
		clr <= clr_req;
		pend_en = en;
		pend_acc = accepted;
		if (clr_req)
			ref_q.delete();				// Clear empties the model too
		else
		begin
			if (accepted)
				pend_dat = ref_q.pop_front();
			if (wr)
				ref_q.push_back(d);
		end
	endtask

	task automatic idle_cycles(input int n);
		logic acc;
		repeat (n)
			drive_cycle(1'b0, 1'b0, 1'b1, 1'b0, acc);
	endtask

	task automatic check_status();
		wrds_t exp_wrds;
		logic exp_empty;
		logic exp_full;
		exp_wrds = wrds_t'(ref_q.size());
		exp_empty = (ref_q.size() == 0);
		exp_full = (ref_q.size() == FULL_LEVEL);
		@(outputs_checked);
		check_cnt += 3;
		if (status.wrds !== exp_wrds)
			report_mismatch("word count", 32'(exp_wrds), 32'(status.wrds));
		if (status.empty !== exp_empty)
			report_mismatch("empty", 32'(exp_empty), 32'(status.empty));
		if (status.full !== exp_full)
			report_mismatch("full", 32'(exp_full), 32'(status.full));
	endtask

	task automatic run_case(input int idx);
		int writes_left;
		int reads_left;
		int cyc;
		int errs_before;
		int out_before;
		logic wr;
		logic en;
		logic acc;
		cur_name = case_name[idx];
		writes_left = case_wr[idx];
		reads_left = case_rd[idx];
		cyc = 0;
		errs_before = err_cnt;
		out_before = words_out;
		if (case_rde[idx] != 0)
			repeat (3)
				drive_cycle(1'b0, 1'b1, 1'b1, 1'b0, acc);	// Nothing stored yet
		while ((writes_left > 0 && (ref_q.size() < FULL_LEVEL || reads_left > 0))
			|| (reads_left > 0 && (ref_q.size() > 0 || writes_left > 0)))
		begin
			en = !(case_gap[idx] != 0 && (cyc % case_gap[idx]) == case_gap[idx] - 1);
			wr = (writes_left > 0) && (ref_q.size() < FULL_LEVEL);	// Keep one word free
			drive_cycle(wr, reads_left > 0, en, 1'b0, acc);
			if (wr)
				writes_left--;
			if (acc)
				reads_left--;
			cyc++;
		end
		if (writes_left > 0 || reads_left > 0)
		begin
			err_cnt++;
			$display("Test %s stalled with %0d writes and %0d reads left over",
				cur_name, writes_left, reads_left);
		end
		if (case_clr[idx] != 0)
			drive_cycle(1'b0, 1'b0, 1'b1, 1'b1, acc);
		idle_cycles(2);
		check_status();
		if (err_cnt == errs_before)
			$display("Test %s passed, %0d words out, %0d stored",
				cur_name, words_out - out_before, ref_q.size());
		else
			$display("Test %s failed with %0d errors", cur_name, err_cnt - errs_before);
	endtask

	// Read side checked away from the driving edge
	always @(negedge RST_IN)
	begin
		if (checking)
		begin
			check_cnt++;
			if (rd_data.de !== cur_de)
				report_mismatch("data enable", 32'(cur_de), 32'(rd_data.de));
			else if (cur_de && (rd_data.dat !== cur_dat))
				report_mismatch("read data", 32'(cur_dat), 32'(rd_data.dat));
			if (cur_de && cur_new)
				words_out++;				// Held words not counted twice
			-> outputs_checked;
		end
	end

	always @(posedge RST_IN)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
		begin
			$display("Timeout, the run went past its limit of %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial
	begin
		int fd;
		int total;
		int i;
		int w;
		int r;
		int g;
		int c;
		int e;
		string line;
		string nm;
		CLK_IN = 1'b1;
		clr = 1'b0;
		wr_port = '0;
		rd_en = 1'b0;
		rd = 1'b0;
		pend_en = 1'b0;
		pend_acc = 1'b0;
		pend_dat = '0;
		cur_de = 1'b0;
		cur_new = 1'b0;
		cur_dat = '0;
		checking = 1'b0;
		err_cnt = 0;
		check_cnt = 0;
		words_out = 0;
		cycle_cnt = 0;
		cycle_limit = 0;
		total = 0;
		lfsr = 32'h5cbe;
		cur_name = "reset";
		fd = $fopen("verification/fifo_cases.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open verification/fifo_cases.txt for reading");
			$display("CHECKS FAILED");
			$finish;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				// Comment and blank lines give fewer than six fields
				if ($sscanf(line, "%s %d %d %d %d %d", nm, w, r, g, c, e) == 6
					&& nm[0] != "#")
				begin
					case_name.push_back(nm);
					case_wr.push_back(w);
					case_rd.push_back(r);
					case_gap.push_back(g);
					case_clr.push_back(c);
					case_rde.push_back(e);
					total += w + r;
				end
			end
			$fclose(fd);
			cycle_limit = 20 + 2 * total + 8 * case_name.size();

			repeat (10)
				@(posedge RST_IN);
			CLK_IN <= 1'b0;
			checking = 1'b1;

			for (i = 0; i < case_name.size(); i++)
				run_case(i);

			$display("Done: %0d tests, %0d checks, %0d errors",
				case_name.size(), check_cnt, err_cnt);
			if (err_cnt == 0)
				$display("ALL CHECKS PASSED");
			else
				$display("CHECKS FAILED");
			$finish;
		end
	end

endmodule

// ==== list.f ====
logic/fifo_cfg_pkg.sv
logic/fifo_types_pkg.sv
logic/fifo_ptr_ctrl.sv
logic/fifo_sdp_ram.sv
logic/fifo_status.sv
logic/fifo_top.sv
verification/fifo_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the FIFO and its testbench with Verilator, runs the binary,
# and looks for the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module fifo_tb \
	-Mdir obj_dir \
	-f list.f
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_out=$(./obj_dir/Vfifo_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "ALL CHECKS PASSED"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, pass line not found"
exit 1

// ==== verification/fifo_cases.txt ====
# name writes reads rd_en_gap clear rd_on_empty
# gap N drops rd_en one cycle in N (0 never), clear pulses clr at the end of the test
empty_reads     0  0 0 0 1
stream_8        8  8 0 0 0
fill_15        15  0 0 0 0
drain_15        0 15 0 0 0
wrap_20        20 20 0 0 0
gap_3_burst    12 12 3 0 0
gap_2_burst    10 10 2 0 0
partial_keep    9  4 0 0 0
clear_mid       3  0 0 1 0
after_clear     6  6 0 0 1
refill_15      15  0 0 0 0
gap_drain       0 15 4 0 0
wrap_long      40 40 5 0 0
hold_5          5  0 0 0 0
clear_full     10  0 0 1 0
reads_after     0  0 0 0 1
final_mix      12 12 0 0 0
